//--- dec_checker.sv
`default_nettype none
`timescale 1ns/1ps

module dec_checker (
  input  wire       iclk,
  input  wire       ireset,
  input  wire       write,
  input  wire       wfull,
  input  wire       rempty,
  input  wire [3:0] waddr
);

  // ----------------------------------------
  // write side protocol
  // ----------------------------------------

  // status pulse comes after the last write
  a_write_wfull_excl : assert property (@(posedge iclk) disable iff (ireset)
    !(write && wfull))
    else $error("write and wfull high in the same cycle");

  a_wfull_pulse : assert property (@(posedge iclk) disable iff (ireset)
    wfull |=> !wfull)
    else $error("wfull held longer than one cycle");

  // address stays inside the code length
  a_waddr_range : assert property (@(posedge iclk) disable iff (ireset)
    write |-> (waddr < dec_pkg::cN))
    else $error("waddr out of range during write");

  // ----------------------------------------
  // read side and reset
  // ----------------------------------------

  a_rempty_pulse : assert property (@(posedge iclk) disable iff (ireset)
    rempty |=> !rempty)
    else $error("rempty held longer than one cycle");

  // strobes quiet while in reset
  a_reset_quiet : assert property (@(posedge iclk)
    ireset |-> (!write && !wfull && !rempty))
    else $error("strobe active during reset");

endmodule

bind dec_top dec_checker u_checker (
  .iclk   (iclk),
  .ireset (ireset),
  .write  (write),
  .wfull  (wfull),
  .rempty (rempty),
  .waddr  (waddr)
);

`default_nettype wire

//--- dec_node_engine.sv
`default_nettype none
`timescale 1ns/1ps

module dec_node_engine #(
  parameter int pLLR_W       = 8,
  parameter int pNORM_FACTOR = 7
) (
  input  logic              iclk,
  input  logic              ireset,
  // channel llr load
  input  logic              llr_load,
  input  dec_pkg::col_idx_t load_idx,
  input  logic [pLLR_W-1:0] rllr,
  // iteration steps
  input  logic              cnode_step,
  input  logic              vnode_step,
  // decisions
  output dec_pkg::bits_t    hard_bits,
  output dec_pkg::bits_t    chan_bits,
  output logic              syndrome_ok
);

  // message, magnitude, column sum and scaling widths
  localparam int cMSG_W  = pLLR_W + 2;
  localparam int cMAG_W  = cMSG_W - 1;
  localparam int cTOT_W  = cMSG_W + 2;
  localparam int cPROD_W = cMAG_W + 4;
  localparam logic [cMAG_W-1:0] cMAG_MAX = '1;

  logic signed [pLLR_W-1:0] chan_llr [dec_pkg::cN];
  logic signed [cMSG_W-1:0] c2v      [dec_pkg::cEDGES];
  logic signed [cMSG_W-1:0] c2v_new  [dec_pkg::cEDGES];
  logic signed [cMSG_W-1:0] v2c      [dec_pkg::cEDGES];
  logic        [cMAG_W-1:0] v2c_mag  [dec_pkg::cEDGES];
  logic signed [cTOT_W-1:0] total    [dec_pkg::cN];
  dec_pkg::bits_t           hd_next;
  logic [dec_pkg::cM-1:0]   syn;

  // symmetric clip to the message range
  function automatic logic signed [cMSG_W-1:0] sat_msg(input logic signed [cTOT_W-1:0] x);
    logic signed [cTOT_W-1:0] lim;
    lim = cTOT_W'({1'b0, cMAG_MAX});
    if (x > lim) begin
      return lim[cMSG_W-1:0];
    end
    else if (x < -lim) begin
      return -lim[cMSG_W-1:0];
    end
    return x[cMSG_W-1:0];
  endfunction

  // ----------------------------------------
  // variable node side
  // ----------------------------------------

  // channel llr plus both incoming check messages
  always_comb begin
    for (int c = 0; c < dec_pkg::cN; c++) begin
      total[c]     = cTOT_W'(chan_llr[c]);
      chan_bits[c] = chan_llr[c][pLLR_W-1];
    end
    for (int e = 0; e < dec_pkg::cEDGES; e++) begin
      total[dec_pkg::cROW_COLS[e]] = total[dec_pkg::cROW_COLS[e]] + cTOT_W'(c2v[e]);
    end
  end

  // extrinsic message per edge, own contribution removed
  always_comb begin
    for (int e = 0; e < dec_pkg::cEDGES; e++) begin
      v2c[e]     = sat_msg(total[dec_pkg::cROW_COLS[e]] - cTOT_W'(c2v[e]));
      v2c_mag[e] = v2c[e][cMSG_W-1] ? cMAG_W'(-v2c[e]) : cMAG_W'(v2c[e]);
    end
  end

  // hard decision and row parity
  always_comb begin
    for (int c = 0; c < dec_pkg::cN; c++) begin
      hd_next[c] = total[c][cTOT_W-1];
    end
    for (int r = 0; r < dec_pkg::cM; r++) begin
      syn[r] = 1'b0;
      for (int j = 0; j < dec_pkg::cROW_W; j++) begin
        syn[r] = syn[r] ^ hd_next[dec_pkg::cROW_COLS[r*dec_pkg::cROW_W+j]];
      end
    end
  end

  // ----------------------------------------
  // check node side, normalized min-sum
  // ----------------------------------------

  always_comb begin
    logic               sgn;
    logic [cMAG_W-1:0]  mn;
    logic [cPROD_W-1:0] prod;
    for (int r = 0; r < dec_pkg::cM; r++) begin
      for (int k = 0; k < dec_pkg::cROW_W; k++) begin
        sgn = 1'b0;
        mn  = cMAG_MAX;
        // sign product and min over the other three edges
        for (int j = 0; j < dec_pkg::cROW_W; j++) begin
          if (j != k) begin
            sgn = sgn ^ v2c[r*dec_pkg::cROW_W+j][cMSG_W-1];
            if (v2c_mag[r*dec_pkg::cROW_W+j] < mn) begin
              mn = v2c_mag[r*dec_pkg::cROW_W+j];
            end
          end
        end
        // scale in eighths, floor
        prod = (cPROD_W'(mn) * cPROD_W'(pNORM_FACTOR)) >> 3;
        if (prod > cPROD_W'(cMAG_MAX)) begin
          prod = cPROD_W'(cMAG_MAX);
        end
        c2v_new[r*dec_pkg::cROW_W+k] = sgn ? -$signed({1'b0, prod[cMAG_W-1:0]}) :
                                              $signed({1'b0, prod[cMAG_W-1:0]});
      end
    end
  end

  // ----------------------------------------
  // storage
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    if (llr_load) begin
      chan_llr[load_idx] <= rllr;
    end
    // new frame starts from zero check messages
    if (llr_load && (load_idx == '0)) begin
      for (int e = 0; e < dec_pkg::cEDGES; e++) begin
        c2v[e] <= '0;
      end
    end
    else if (cnode_step) begin
      c2v <= c2v_new;
    end
    if (vnode_step) begin
      hard_bits <= hd_next;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      syndrome_ok <= 1'b0;
    end
    else if (llr_load && (load_idx == '0)) begin
      syndrome_ok <= 1'b0;
    end
    else if (vnode_step) begin
      syndrome_ok <= ~|syn;
    end
  end

endmodule

`default_nettype wire

//--- dec_pkg.sv
`default_nettype none

package dec_pkg;

  // ----------------------------------------
  // code geometry
  // ----------------------------------------

  // code bits (variable nodes)
  localparam int cN     = 12;
  // parity rows (check nodes)
  localparam int cM     = 6;
  // ones per row, regular check degree
  localparam int cROW_W = 4;
  // total edges in the tanner graph
  localparam int cEDGES = cM * cROW_W;

  // ----------------------------------------
  // parity-check table
  // ----------------------------------------

  // column index of every edge, row major
  // rows 0..2 split the columns into groups of four
  // rows 3..5 interleave across the groups
  // every column ends up with degree 2
  localparam int cROW_COLS [cEDGES] = '{
    0, 1,  2, 3,
    4, 5,  6, 7,
    8, 9, 10, 11,
    0, 5, 10, 3,
    1, 6, 11, 4,
    2, 7,  8, 9
  };

  // ----------------------------------------
  // interface timing
  // ----------------------------------------

  // read buffer returns data this many cycles after raddr
  localparam int cRDAT_DELAY = 2;

  // ----------------------------------------
  // index and vector types
  // ----------------------------------------

  // bit / column address, also used for raddr and waddr
  typedef logic [3:0] col_idx_t;

  // one flag per code column
  typedef logic [cN-1:0] bits_t;

endpackage

`default_nettype wire

//--- dec_result.sv
`default_nettype none
`timescale 1ns/1ps

module dec_result #(
  parameter int pTAG_W = 4,
  parameter int pERR_W = 8
) (
  input  logic              iclk,
  input  logic              ireset,
  // frame control from the schedule
  input  logic              frame_start,
  input  logic [pTAG_W-1:0] rtag,
  input  logic              write_step,
  input  dec_pkg::col_idx_t write_idx,
  input  logic              frame_done,
  // engine decisions
  input  dec_pkg::bits_t    hard_bits,
  input  dec_pkg::bits_t    chan_bits,
  input  logic              syndrome_ok,
  // write side
  output logic              write,
  output dec_pkg::col_idx_t waddr,
  output logic              wdat,
  output logic              wfull,
  output logic [pERR_W-1:0] werr,
  output logic              wdecfail,
  output logic [pTAG_W-1:0] wtag
);

  logic [pTAG_W-1:0] tag_q;
  logic [pERR_W-1:0] err_cnt;
  logic              bit_err;

  // decoded bit flipped against the channel sign
  assign bit_err = hard_bits[write_idx] ^ chan_bits[write_idx];

  // ----------------------------------------
  // write strobes
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      write <= 1'b0;
      wfull <= 1'b0;
    end
    else begin
      write <= write_step;
      wfull <= frame_done;
    end
  end

  // one hard bit per step
  always_ff @(posedge iclk) begin
    waddr <= write_idx;
    wdat  <= hard_bits[write_idx];
  end

  // ----------------------------------------
  // bit error count and frame status
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      err_cnt <= '0;
    end
    else if (frame_start) begin
      err_cnt <= '0;
    end
    else if (write_step && bit_err) begin
      err_cnt <= err_cnt + 1'b1;
    end
  end

  // tag held per frame, status held until next wfull
  always_ff @(posedge iclk) begin
    if (frame_start) begin
      tag_q <= rtag;
    end
    if (frame_done) begin
      werr     <= err_cnt;
      wdecfail <= ~syndrome_ok;
      wtag     <= tag_q;
    end
  end

endmodule

`default_nettype wire

//--- dec_schedule.sv
`default_nettype none
`timescale 1ns/1ps

module dec_schedule (
  input  logic              iclk,
  input  logic              ireset,
  // read side
  input  logic              rbuf_full,
  input  logic [7:0]        niter,
  input  logic              fmode,
  output dec_pkg::col_idx_t raddr,
  output logic              rempty,
  output logic              llr_load,
  output dec_pkg::col_idx_t load_idx,
  // iteration control
  input  logic              syndrome_ok,
  output logic              cnode_step,
  output logic              vnode_step,
  // write side
  input  logic              wbuf_empty,
  output logic              write_step,
  output dec_pkg::col_idx_t write_idx,
  output logic              frame_start,
  output logic              frame_done,
  output logic [7:0]        used_niter
);

  localparam dec_pkg::col_idx_t cLAST = dec_pkg::col_idx_t'(dec_pkg::cN - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_read,
    st_flush,
    st_comp,
    st_wait,
    st_write,
    st_done
  } state_t;

  state_t                             state;
  logic [7:0]                         niter_q;
  logic                               fmode_q;
  logic [7:0]                         iter_cnt;
  logic                               phase;
  dec_pkg::col_idx_t                  widx;
  logic [dec_pkg::cRDAT_DELAY-1:0]    rd_val;
  dec_pkg::col_idx_t                  rd_idx [dec_pkg::cRDAT_DELAY];
  logic                               last_load;
  logic                               stop;

  // ----------------------------------------
  // step strobes decoded from state
  // ----------------------------------------

  // first read cycle, raddr still at 0
  assign frame_start = (state == st_read) && (raddr == '0);

  // aligned with rllr coming back from the buffer
  assign llr_load  = rd_val[dec_pkg::cRDAT_DELAY-1];
  assign load_idx  = rd_idx[dec_pkg::cRDAT_DELAY-1];
  assign last_load = llr_load && (load_idx == cLAST);

  // stop checked before each check-node step
  // at least one full iteration per frame
  assign stop = (iter_cnt != '0) &&
                ((iter_cnt >= niter_q) || (fmode_q && syndrome_ok));

  assign cnode_step = (state == st_comp) && !phase && !stop;
  assign vnode_step = (state == st_comp) && phase;

  assign write_step = (state == st_write);
  assign write_idx  = widx;
  assign frame_done = (state == st_done);

  // ----------------------------------------
  // read latency delay line
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    rd_idx[0] <= raddr;
    for (int i = 1; i < dec_pkg::cRDAT_DELAY; i++) begin
      rd_idx[i] <= rd_idx[i-1];
    end
  end

  // ----------------------------------------
  // frame fsm
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state      <= st_idle;
      raddr      <= '0;
      widx       <= '0;
      phase      <= 1'b0;
      iter_cnt   <= '0;
      niter_q    <= '0;
      fmode_q    <= 1'b0;
      rempty     <= 1'b0;
      rd_val     <= '0;
      used_niter <= '0;
    end
    else begin
      // one cycle after the last llr lands
      rempty <= last_load;
      rd_val <= {rd_val[dec_pkg::cRDAT_DELAY-2:0], (state == st_read)};
      case (state)
        st_idle : begin
          if (rbuf_full) begin
            state <= st_read;
          end
        end
        st_read : begin
          // frame parameters latched with address 0
          if (frame_start) begin
            niter_q  <= niter;
            fmode_q  <= fmode;
            iter_cnt <= '0;
            phase    <= 1'b0;
          end
          if (raddr == cLAST) begin
            raddr <= '0;
            state <= st_flush;
          end
          else begin
            raddr <= raddr + 1'b1;
          end
        end
        st_flush : begin
          if (last_load) begin
            state <= st_comp;
          end
        end
        st_comp : begin
          // phase 0 check nodes, phase 1 variable nodes
          if (phase) begin
            phase    <= 1'b0;
            iter_cnt <= iter_cnt + 1'b1;
          end
          else if (stop) begin
            state <= st_wait;
          end
          else begin
            phase <= 1'b1;
          end
        end
        st_wait : begin
          // hold results until the sink has room
          if (wbuf_empty) begin
            widx  <= '0;
            state <= st_write;
          end
        end
        st_write : begin
          widx <= widx + 1'b1;
          if (widx == cLAST) begin
            state <= st_done;
          end
        end
        st_done : begin
          used_niter <= iter_cnt;
          widx       <= '0;
          state      <= st_idle;
        end
        default : begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- dec_testdata.txt
// niter fmode tag | llr0..llr11 (8-bit two's complement) |
// expected bits (bit i = column i) err_count decode_fail used_niter
03 1 1 14 14 14 14 14 14 14 14 14 14 14 14 000 00 0 01
03 0 2 14 14 14 14 14 14 14 14 14 14 14 14 000 00 0 03
05 1 3 fb 14 14 14 14 14 14 14 14 14 14 14 000 01 0 01
02 0 4 fb 14 14 14 14 14 14 14 14 14 14 14 000 01 0 02
01 1 5 9c 9c 14 14 14 14 14 14 14 14 14 14 003 00 1 01
04 1 6 ec 14 14 ec 14 14 14 14 14 14 14 14 009 00 0 01
02 1 7 9c 14 14 14 14 14 14 14 14 14 14 14 009 01 0 01

//--- dec_top.sv
`default_nettype none
`timescale 1ns/1ps

module dec_top #(
  parameter int pLLR_W       = 8,
  parameter int pNORM_FACTOR = 7,
  parameter int pTAG_W       = 4,
  parameter int pERR_W       = 8
) (
  input  logic              iclk,
  input  logic              ireset,
  // read buffer side
  input  logic              rbuf_full,
  input  logic [7:0]        niter,
  input  logic              fmode,
  input  logic [pTAG_W-1:0] rtag,
  input  logic [pLLR_W-1:0] rllr,
  output dec_pkg::col_idx_t raddr,
  output logic              rempty,
  // write buffer side
  input  logic              wbuf_empty,
  output logic              write,
  output dec_pkg::col_idx_t waddr,
  output logic              wdat,
  output logic              wfull,
  output logic [pERR_W-1:0] werr,
  output logic              wdecfail,
  output logic [pTAG_W-1:0] wtag,
  output logic [7:0]        used_niter
);

  // ----------------------------------------
  // internal nets
  // ----------------------------------------

  logic              llr_load;
  dec_pkg::col_idx_t load_idx;
  logic              cnode_step;
  logic              vnode_step;
  logic              write_step;
  dec_pkg::col_idx_t write_idx;
  logic              frame_start;
  logic              frame_done;
  dec_pkg::bits_t    hard_bits;
  dec_pkg::bits_t    chan_bits;
  logic              syndrome_ok;

  // decode, frame and iteration sequencing
  dec_schedule u_schedule (
    .iclk        (iclk),
    .ireset      (ireset),
    .rbuf_full   (rbuf_full),
    .niter       (niter),
    .fmode       (fmode),
    .raddr       (raddr),
    .rempty      (rempty),
    .llr_load    (llr_load),
    .load_idx    (load_idx),
    .syndrome_ok (syndrome_ok),
    .cnode_step  (cnode_step),
    .vnode_step  (vnode_step),
    .wbuf_empty  (wbuf_empty),
    .write_step  (write_step),
    .write_idx   (write_idx),
    .frame_start (frame_start),
    .frame_done  (frame_done),
    .used_niter  (used_niter)
  );

  // execute, min-sum datapath
  dec_node_engine #(
    .pLLR_W       (pLLR_W),
    .pNORM_FACTOR (pNORM_FACTOR)
  ) u_engine (
    .iclk        (iclk),
    .ireset      (ireset),
    .llr_load    (llr_load),
    .load_idx    (load_idx),
    .rllr        (rllr),
    .cnode_step  (cnode_step),
    .vnode_step  (vnode_step),
    .hard_bits   (hard_bits),
    .chan_bits   (chan_bits),
    .syndrome_ok (syndrome_ok)
  );

  // result, write-out and frame status
  dec_result #(
    .pTAG_W (pTAG_W),
    .pERR_W (pERR_W)
  ) u_result (
    .iclk        (iclk),
    .ireset      (ireset),
    .frame_start (frame_start),
    .rtag        (rtag),
    .write_step  (write_step),
    .write_idx   (write_idx),
    .frame_done  (frame_done),
    .hard_bits   (hard_bits),
    .chan_bits   (chan_bits),
    .syndrome_ok (syndrome_ok),
    .write       (write),
    .waddr       (waddr),
    .wdat        (wdat),
    .wfull       (wfull),
    .werr        (werr),
    .wdecfail    (wdecfail),
    .wtag        (wtag)
  );

endmodule

`default_nettype wire

//--- flist.f
dec_pkg.sv
dec_schedule.sv
dec_node_engine.sv
dec_result.sv
dec_top.sv
dec_checker.sv
tb_clkgen.sv
tb_dec.sv

//--- run.sh
#!/bin/sh
# compile and run with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
( verilator --binary --timing --assert -Wno-fatal --top-module tb_dec \
    -f flist.f -o sim_dec && ./obj_dir/sim_dec ) > sim.log 2>&1 \
  || echo "Test failed" >> sim.log
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log

//--- tb_clkgen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int pPERIOD   = 100,
  parameter int pRST_CYCS = 5
) (
  output logic iclk,
  output logic ireset
);

  // free running clock, reset released on a falling edge
  initial begin
    iclk   = 1'b0;
    ireset = 1'b1;
    forever #(pPERIOD / 2) iclk = ~iclk;
  end

  initial begin
    repeat (pRST_CYCS) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_dec.sv
`default_nettype none
`timescale 1ns/1ps

module tb_dec;

  localparam int cFRAMES = 7;
  // per record niter fmode tag then 12 llrs then bits err fail used
  localparam int cFIELDS = 19;

  logic       iclk;
  logic       ireset;
  logic       rbuf_full;
  logic [7:0] niter;
  logic       fmode;
  logic [3:0] rtag;
  logic [7:0] rllr;
  logic [3:0] raddr;
  logic       rempty;
  logic       wbuf_empty;
  logic       write;
  logic [3:0] waddr;
  logic       wdat;
  logic       wfull;
  logic [7:0] werr;
  logic       wdecfail;
  logic [3:0] wtag;
  logic [7:0] used_niter;

  logic [15:0] tdata [cFRAMES*cFIELDS];
  logic [7:0]  llr_mem [16];
  logic [3:0]  ra_d1;
  logic [3:0]  ra_d2;
  int          rd_next;
  int          rd_runs;
  logic [11:0] wr_bits;
  logic [11:0] wr_mask;
  int          wr_cnt;
  int          rempty_cnt;
  int          wfull_cnt;
  int          wfull_total;
  int          errors;
  int          checks;
  integer      seed;

  tb_clkgen u_clkgen (
    .iclk   (iclk),
    .ireset (ireset)
  );

  dec_top u_dut (
    .iclk       (iclk),
    .ireset     (ireset),
    .rbuf_full  (rbuf_full),
    .niter      (niter),
    .fmode      (fmode),
    .rtag       (rtag),
    .rllr       (rllr),
    .raddr      (raddr),
    .rempty     (rempty),
    .wbuf_empty (wbuf_empty),
    .write      (write),
    .waddr      (waddr),
    .wdat       (wdat),
    .wfull      (wfull),
    .werr       (werr),
    .wdecfail   (wdecfail),
    .wtag       (wtag),
    .used_niter (used_niter)
  );

  task automatic check_val(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // sample outputs and model both buffers once per cycle
  // ----------------------------------------

  task automatic tick();
    @(negedge iclk);
    // read buffer answers two cycles after raddr
    rllr  = llr_mem[ra_d2];
    ra_d2 = ra_d1;
    ra_d1 = raddr;
    // raddr 0..11 on consecutive cycles counts as one frame read
    if ((raddr == rd_next) && (raddr == 11)) begin
      rd_runs++;
      rd_next = 0;
    end
    else if (raddr == rd_next) begin
      rd_next++;
    end
    else if (raddr == 0) begin
      rd_next = 1;
    end
    else begin
      rd_next = 0;
    end
    if (rempty) begin
      rempty_cnt++;
    end
    if (write) begin
      if (!wbuf_empty) begin
        errors++;
        $display("write seen at %0t while the write buffer was not empty", $time);
      end
      if (waddr < 12) begin
        wr_bits[waddr] = wdat;
        wr_mask[waddr] = 1'b1;
      end
      wr_cnt++;
    end
    if (wfull) begin
      wfull_cnt++;
      wfull_total++;
    end
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  initial begin
    #(64'(cFRAMES) * 700 * 100);
    $display("timeout, the decoder did not finish all frames in time");
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------
  // frame loop
  // ----------------------------------------

  initial begin
    int b;
    int dly;
    int err_before;
    rbuf_full   = 1'b0;
    niter       = '0;
    fmode       = 1'b0;
    rtag        = '0;
    rllr        = '0;
    wbuf_empty  = 1'b0;
    ra_d1       = '0;
    ra_d2       = '0;
    rd_next     = 0;
    rd_runs     = 0;
    errors      = 0;
    checks      = 0;
    wfull_total = 0;
    seed        = 32'h926e_4c2f;
    for (int i = 0; i < 16; i++) begin
      llr_mem[i] = '0;
    end
    $readmemh("dec_testdata.txt", tdata);
    @(negedge ireset);
    repeat (2) tick();
    for (int f = 0; f < cFRAMES; f++) begin
      b          = f * cFIELDS;
      err_before = errors;
      for (int i = 0; i < 12; i++) begin
        llr_mem[i] = tdata[b+3+i][7:0];
      end
      rd_runs    = 0;
      wr_bits    = '0;
      wr_mask    = '0;
      wr_cnt     = 0;
      rempty_cnt = 0;
      wfull_cnt  = 0;
      niter      = tdata[b][7:0];
      fmode      = tdata[b+1][0];
      rtag       = tdata[b+2][3:0];
      rbuf_full  = 1'b1;
      while (rempty_cnt == 0) tick();
      rbuf_full = 1'b0;
      // frame parameters only count on the first read cycle
      niter = ~niter;
      fmode = ~fmode;
      rtag  = ~rtag;
      // sink busy for a random stretch
      dly = $unsigned($random(seed)) % 21;
      repeat (dly) tick();
      wbuf_empty = 1'b1;
      while (wfull_cnt == 0) tick();
      check_val("full read runs", rd_runs, 1);
      check_val("rempty pulses", rempty_cnt, 1);
      check_val("write count", wr_cnt, 12);
      check_val("write address mask", wr_mask, 12'hfff);
      check_val("decoded bits", wr_bits, tdata[b+15][11:0]);
      check_val("werr", werr, tdata[b+16][7:0]);
      check_val("wdecfail", wdecfail, tdata[b+17][0]);
      check_val("used_niter", used_niter, tdata[b+18][7:0]);
      check_val("wtag", wtag, tdata[b+2][3:0]);
      wbuf_empty = 1'b0;
      repeat (3) tick();
      check_val("wfull pulses", wfull_cnt, 1);
      $display("frame %0d tag %0d: %s", f, tdata[b+2][3:0],
               (errors == err_before) ? "ok" : "errors");
    end
    check_val("total wfull pulses", wfull_total, cFRAMES);
    $display("frames %0d, checks %0d, errors %0d", cFRAMES, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end
    else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
